/* src/fp_pkg.sv */
`default_nettype none

package fp_pkg;

    // --------------------
    // Widths
    // --------------------

    // One endpoint word on the host bus
    localparam int EP_W       = 16;
    // Endpoint address field
    localparam int EP_ADDR_W  = 8;
    // Controller output sample and its channel number
    localparam int LOG_DATA_W = 18;
    localparam int LOG_CHAN_W = 5;
    // Config data, built from four wire-in slices
    localparam int CFG_DATA_W = 48;
    // Bits taken from each data wire-in, data3 most significant
    localparam int CFG_SLICE_W = CFG_DATA_W / 4;
    // Fill count field of the status word (bits 10 to 0)
    localparam int STAT_CNT_W = 11;

    // Config address that selects the pipe channel
    localparam logic [EP_W-1:0] PIPE_CHAN_ADDR = 16'h0100;

    // --------------------
    // Endpoint map
    // --------------------

    // Wire-ins below 0x20, wire-outs 0x20..0x3F, triggers from 0x40, pipes from 0xA0
    typedef enum logic [EP_ADDR_W-1:0] {
        EP_WR_ADDR  = 8'h01,
        EP_WR_CHAN  = 8'h02,
        EP_DATA0    = 8'h03,
        EP_DATA1    = 8'h04,
        EP_DATA2    = 8'h05,
        EP_DATA3    = 8'h06,
        // Log channel k sits at base plus k
        EP_LOG_BASE = 8'h20,
        EP_STATUS   = 8'h3F,
        EP_TRIG     = 8'h40,
        EP_PIPE     = 8'hA0
    } ep_addr_e;

    // Bit positions inside the trigger word
    typedef enum logic [3:0] {
        TRIG_LOG_CLEAR  = 4'd0,
        TRIG_ADC_CSTART = 4'd1,
        TRIG_WR_EN      = 4'd2,
        TRIG_DAC_RSET   = 4'd3
    } trig_bit_e;

    // --------------------
    // Shared structs
    // --------------------

    // One host bus cycle, wr or rd held for a single clock
    typedef struct packed {
        logic                 wr;
        logic                 rd;
        logic [EP_ADDR_W-1:0] addr;
        logic [EP_W-1:0]      wdata;
    } host_cmd_t;

    // Config write toward the controller
    typedef struct packed {
        logic                  en;
        logic [EP_W-1:0]       addr;
        logic [LOG_CHAN_W-1:0] chan;
        logic [CFG_DATA_W-1:0] data;
    } cfg_write_t;

    // Sample strobe from the controller, no back-pressure
    typedef struct packed {
        logic                  dv;
        logic [LOG_CHAN_W-1:0] chan;
        logic [LOG_DATA_W-1:0] data;
    } log_sample_t;

endpackage

`default_nettype wire

/* src/fp_host_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_host_decode import fp_pkg::*; (
    input  wire                   sys_clk_in,
    input  wire                   sys_rst_out,
    input  wire host_cmd_t        host_cmd,
    output cfg_write_t            cfg_out,
    output logic                  adc_cstart,
    output logic                  dac_rset,
    output logic                  log_clear,
    output logic [LOG_CHAN_W-1:0] pipe_chan
);

    // Staged config word
    logic [EP_W-1:0]                  wr_addr;
    logic [LOG_CHAN_W-1:0]            wr_chan;
    logic [3:0][CFG_SLICE_W-1:0]      wr_data;

    // Registered write enable pulse
    logic                             wr_en;

    // Host write aimed at the trigger endpoint
    logic                             trig_hit;

    // --------------------
    // Wire-ins
    // --------------------

    // Each wire-in updates on the edge that ends the write cycle
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            wr_addr <= '0;
            wr_chan <= '0;
            wr_data <= '0;
        end else if (host_cmd.wr) begin
            case (host_cmd.addr)
                EP_WR_ADDR: wr_addr <= host_cmd.wdata;
                // Only the channel bits are kept
                EP_WR_CHAN: wr_chan <= host_cmd.wdata[LOG_CHAN_W-1:0];
                // Low slice of each data word
                EP_DATA0:   wr_data[0] <= host_cmd.wdata[CFG_SLICE_W-1:0];
                EP_DATA1:   wr_data[1] <= host_cmd.wdata[CFG_SLICE_W-1:0];
                EP_DATA2:   wr_data[2] <= host_cmd.wdata[CFG_SLICE_W-1:0];
                EP_DATA3:   wr_data[3] <= host_cmd.wdata[CFG_SLICE_W-1:0];
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // Triggers
    // --------------------

    assign trig_hit = host_cmd.wr && (host_cmd.addr == EP_TRIG);

    // One-cycle pulses in the cycle after the trigger write
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            log_clear  <= 1'b0;
            adc_cstart <= 1'b0;
            wr_en      <= 1'b0;
            dac_rset   <= 1'b0;
        end else begin
            log_clear  <= trig_hit && host_cmd.wdata[TRIG_LOG_CLEAR];
            adc_cstart <= trig_hit && host_cmd.wdata[TRIG_ADC_CSTART];
            wr_en      <= trig_hit && host_cmd.wdata[TRIG_WR_EN];
            dac_rset   <= trig_hit && host_cmd.wdata[TRIG_DAC_RSET];
        end
    end

    // --------------------
    // Config write out
    // --------------------

    // Fields show the wire-ins while en is high
    assign cfg_out.en   = wr_en;
    assign cfg_out.addr = wr_addr;
    assign cfg_out.chan = wr_chan;
    // Slice 3 lands in the top bits
    assign cfg_out.data = wr_data;

    // --------------------
    // Pipe channel select
    // --------------------

    // Taken one edge after the wr_en pulse
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            pipe_chan <= '0;
        end else if (wr_en && (wr_addr == PIPE_CHAN_ADDR)) begin
            pipe_chan <= wr_chan;
        end
    end

endmodule

`default_nettype wire

/* src/fp_log_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_log_capture import fp_pkg::*; #(
    parameter int N_LOG = 8
) (
    input  wire                         sys_clk_in,
    input  wire                         sys_rst_out,
    input  wire log_sample_t            log_in,
    input  wire [LOG_CHAN_W-1:0]        pipe_chan,
    input  wire                         log_clear,
    output logic [N_LOG-1:0][EP_W-1:0]  log_words,
    output logic                        pipe_push,
    output logic [EP_W-1:0]             pipe_word
);

    // Newest full-width sample per channel
    logic [N_LOG-1:0][LOG_DATA_W-1:0] log_mem;

    // One-hot channel match of the incoming sample
    logic [N_LOG-1:0]                 chan_hit;
    // Sample lands in a channel that exists
    logic                             chan_valid;

    // --------------------
    // Channel match
    // --------------------

    // Channels of N_LOG or above match nothing
    always_comb begin
        chan_hit = '0;
        for (int k = 0; k < N_LOG; k++) begin
            chan_hit[k] = log_in.dv && (log_in.chan == LOG_CHAN_W'(k));
        end
    end

    assign chan_valid = |chan_hit;

    // --------------------
    // Log registers
    // --------------------

    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out || log_clear) begin
            log_mem <= '0;
        end else begin
            for (int k = 0; k < N_LOG; k++) begin
                if (chan_hit[k]) begin
                    log_mem[k] <= log_in.data;
                end
            end
        end
    end

    // Host sees the upper 16 bits only
    always_comb begin
        for (int k = 0; k < N_LOG; k++) begin
            log_words[k] = log_mem[k][LOG_DATA_W-1 -: EP_W];
        end
    end

    // --------------------
    // Pipe feed
    // --------------------

    // Push registered on the same edge as the log update
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out || log_clear) begin
            pipe_push <= 1'b0;
        end else begin
            pipe_push <= chan_valid && (log_in.chan == pipe_chan);
        end
    end

    // Payload follows every valid sample, push qualifies it
    always_ff @(posedge sys_clk_in) begin
        if (log_in.dv) begin
            pipe_word <= log_in.data[LOG_DATA_W-1 -: EP_W];
        end
    end

endmodule

`default_nettype wire

/* src/fp_pipe_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_pipe_fifo import fp_pkg::*; #(
    parameter int FIFO_AW = 10
) (
    input  wire                  sys_clk_in,
    input  wire                  sys_rst_out,
    input  wire                  flush,
    input  wire                  push,
    input  wire [EP_W-1:0]       wdata,
    input  wire                  pop,
    output logic [EP_W-1:0]      rdata,
    output logic [FIFO_AW:0]     count,
    output logic                 overflow
);

    localparam int DEPTH = 2 ** FIFO_AW;

    // Word storage
    logic [EP_W-1:0]    mem [DEPTH];

    // Circular pointers
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;

    logic               full;
    logic               empty;
    logic               do_push;
    logic               do_pop;

    // --------------------
    // Status
    // --------------------

    // Count never exceeds DEPTH, so the MSB alone marks full
    assign full  = count[FIFO_AW];
    assign empty = (count == '0);

    // Full drops the word, empty ignores the pop
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // --------------------
    // Pointers and count
    // --------------------

    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out || flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset or flush
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge sys_clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Head word, valid whenever count is non-zero
    assign rdata = mem[rd_ptr];

endmodule

`default_nettype wire

/* src/fp_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_readout import fp_pkg::*; #(
    parameter int N_LOG = 8
) (
    input  wire                          sys_clk_in,
    input  wire                          sys_rst_out,
    input  wire host_cmd_t               host_cmd,
    input  wire [N_LOG-1:0][EP_W-1:0]    log_words,
    input  wire [EP_W-1:0]               pipe_data,
    input  wire [STAT_CNT_W-1:0]         fill_count,
    input  wire                          overflow,
    output logic                         pipe_pop,
    output logic [EP_W-1:0]              host_rdata,
    output logic                         host_rvalid
);

    // Class of the endpoint being read
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_LOG,
        SEL_STATUS,
        SEL_PIPE
    } rd_sel_e;

    rd_sel_e         rd_sel;
    logic [EP_W-1:0] log_word;
    logic [EP_W-1:0] status_word;
    logic [EP_W-1:0] rd_word;
    logic            pipe_ready;

    // --------------------
    // Address decode
    // --------------------

    // Log range runs from the base up to just below status
    always_comb begin
        if (host_cmd.addr == EP_STATUS) begin
            rd_sel = SEL_STATUS;
        end else if (host_cmd.addr == EP_PIPE) begin
            rd_sel = SEL_PIPE;
        end else if (host_cmd.addr >= EP_LOG_BASE && host_cmd.addr < EP_STATUS) begin
            rd_sel = SEL_LOG;
        end else begin
            rd_sel = SEL_NONE;
        end
    end

    // Channels past N_LOG fall through as zero
    always_comb begin
        log_word = '0;
        for (int k = 0; k < N_LOG; k++) begin
            if (host_cmd.addr == EP_LOG_BASE + EP_ADDR_W'(k)) begin
                log_word = log_words[k];
            end
        end
    end

    // Overflow on top, fill count in the low bits
    always_comb begin
        status_word                   = '0;
        status_word[EP_W-1]           = overflow;
        status_word[STAT_CNT_W-1:0]   = fill_count;
    end

    assign pipe_ready = (fill_count != '0);

    // Pop only when there is a word to give
    assign pipe_pop = host_cmd.rd && (rd_sel == SEL_PIPE) && pipe_ready;

    // --------------------
    // Read mux
    // --------------------

    always_comb begin
        case (rd_sel)
            SEL_LOG:    rd_word = log_word;
            SEL_STATUS: rd_word = status_word;
            // Empty pipe reads back zero
            SEL_PIPE:   rd_word = pipe_ready ? pipe_data : '0;
            default:    rd_word = '0;
        endcase
    end

    // Data and valid one cycle after rd
    always_ff @(posedge sys_clk_in) begin
        if (sys_rst_out) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= host_cmd.rd;
        end
    end

    always_ff @(posedge sys_clk_in) begin
        if (host_cmd.rd) begin
            host_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* src/frontpanel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontpanel_top import fp_pkg::*; #(
    parameter int N_LOG   = 8,
    parameter int FIFO_AW = 10
) (
    input  wire                sys_clk_in,
    input  wire                sys_rst_out,
    input  wire host_cmd_t     host_cmd,
    input  wire log_sample_t   log_in,
    output cfg_write_t         cfg_out,
    output logic               adc_cstart,
    output logic               dac_rset,
    output logic [EP_W-1:0]    host_rdata,
    output logic               host_rvalid
);

    // --------------------
    // Stage links
    // --------------------

    // Decode to capture
    logic [LOG_CHAN_W-1:0]        pipe_chan;
    logic                         log_clear;

    // Capture to FIFO and readout
    logic [N_LOG-1:0][EP_W-1:0]   log_words;
    logic                         pipe_push;
    logic [EP_W-1:0]              pipe_word;

    // FIFO and readout
    logic                         pipe_pop;
    logic [EP_W-1:0]              pipe_data;
    logic [FIFO_AW:0]             fifo_count;
    logic [STAT_CNT_W-1:0]        fill_count;
    logic                         overflow;

    // Count sized to the status field
    assign fill_count = STAT_CNT_W'(fifo_count);

    // --------------------
    // Stages
    // --------------------

    // Host writes, triggers, pipe channel
    fp_host_decode u_decode (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .host_cmd    (host_cmd),
        .cfg_out     (cfg_out),
        .adc_cstart  (adc_cstart),
        .dac_rset    (dac_rset),
        .log_clear   (log_clear),
        .pipe_chan   (pipe_chan)
    );

    // Per-channel log and pipe feed
    fp_log_capture #(
        .N_LOG (N_LOG)
    ) u_capture (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .log_in      (log_in),
        .pipe_chan   (pipe_chan),
        .log_clear   (log_clear),
        .log_words   (log_words),
        .pipe_push   (pipe_push),
        .pipe_word   (pipe_word)
    );

    // Log clear also flushes the pipe
    fp_pipe_fifo #(
        .FIFO_AW (FIFO_AW)
    ) u_fifo (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .flush       (log_clear),
        .push        (pipe_push),
        .wdata       (pipe_word),
        .pop         (pipe_pop),
        .rdata       (pipe_data),
        .count       (fifo_count),
        .overflow    (overflow)
    );

    // Host read path
    fp_readout #(
        .N_LOG (N_LOG)
    ) u_readout (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .host_cmd    (host_cmd),
        .log_words   (log_words),
        .pipe_data   (pipe_data),
        .fill_count  (fill_count),
        .overflow    (overflow),
        .pipe_pop    (pipe_pop),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

endmodule

`default_nettype wire

/* tb/tb_frontpanel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frontpanel import fp_pkg::*; ();

    localparam int N_LOG      = 8;
    localparam int FIFO_AW    = 10;
    localparam int DEPTH      = 2 ** FIFO_AW;
    localparam int N_TESTS    = 5;
    localparam int CLK_PERIOD = 10;
    // Per-test budget plus room for every FIFO word to go in and come out
    localparam int WATCHDOG_CYCLES = 200 * N_TESTS + 4 * DEPTH;

    logic            sys_clk_in;
    logic            sys_rst_out;
    host_cmd_t       host_cmd;
    log_sample_t     log_in;
    cfg_write_t      cfg_out;
    logic            adc_cstart;
    logic            dac_rset;
    logic [EP_W-1:0] host_rdata;
    logic            host_rvalid;

    // Reference model state
    logic [EP_W-1:0]       model_log [N_LOG];
    logic [EP_W-1:0]       model_pipe [$];
    logic                  model_ovf;
    logic [LOG_CHAN_W-1:0] model_pipe_chan;

    logic [31:0] lfsr_state;
    int          err_count;
    int          pass_tests;
    int          fail_tests;

    frontpanel_top #(
        .N_LOG   (N_LOG),
        .FIFO_AW (FIFO_AW)
    ) u_frontpanel_top (
        .sys_clk_in  (sys_clk_in),
        .sys_rst_out (sys_rst_out),
        .host_cmd    (host_cmd),
        .log_in      (log_in),
        .cfg_out     (cfg_out),
        .adc_cstart  (adc_cstart),
        .dac_rset    (dac_rset),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    // --------------------
    // Clock and watchdog
    // --------------------

    initial begin
        sys_clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk_in = ~sys_clk_in;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk_in);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // --------------------
    // Helpers
    // --------------------

    // Fibonacci LFSR with taps 32 22 2 1
    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [EP_W-1:0] trig_word(input trig_bit_e b);
        return 16'(1) << b;
    endfunction

    // Overflow on top and fill count in bits 10..0
    function automatic logic [EP_W-1:0] expected_status();
        return {model_ovf, 4'b0000, STAT_CNT_W'(model_pipe.size())};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_count++;
        $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    task automatic report_error(input string what);
        err_count++;
        $display("error: %s", what);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge sys_clk_in);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic host_write(input logic [EP_ADDR_W-1:0] addr, input logic [EP_W-1:0] data);
        host_cmd.wr    = 1'b1;
        host_cmd.rd    = 1'b0;
        host_cmd.addr  = addr;
        host_cmd.wdata = data;
        next_cycle();
        host_cmd = '0;
    endtask

    // Data taken in the cycle that rvalid is high
    task automatic host_read(input logic [EP_ADDR_W-1:0] addr, output logic [EP_W-1:0] data);
        int waited;
        host_cmd.wr    = 1'b0;
        host_cmd.rd    = 1'b1;
        host_cmd.addr  = addr;
        host_cmd.wdata = '0;
        next_cycle();
        host_cmd = '0;
        waited   = 0;
        while (!host_rvalid && waited < 8) begin
            next_cycle();
            waited++;
        end
        if (!host_rvalid) begin
            report_error($sformatf("no host_rvalid after read of 0x%0h", addr));
        end else if (waited != 0) begin
            report_error($sformatf("host_rvalid %0d cycles late", waited));
        end
        data = host_rdata;
    endtask

    task automatic check_read(input string name, input logic [EP_ADDR_W-1:0] addr,
                              input logic [EP_W-1:0] exp);
        logic [EP_W-1:0] got;
        host_read(addr, got);
        if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic send_sample(input logic [LOG_CHAN_W-1:0] chan,
                               input logic [LOG_DATA_W-1:0] data);
        int idx;
        log_in.dv   = 1'b1;
        log_in.chan = chan;
        log_in.data = data;
        next_cycle();
        log_in = '0;
        idx    = int'(chan);
        // Out of range channels leave the model alone
        if (idx < N_LOG) begin
            model_log[idx] = data[LOG_DATA_W-1 -: EP_W];
            if (chan == model_pipe_chan) begin
                if (model_pipe.size() < DEPTH) model_pipe.push_back(data[LOG_DATA_W-1 -: EP_W]);
                else model_ovf = 1'b1;
            end
        end
    endtask

    // Stage wire-ins and then fire the write enable
    task automatic write_cfg(input logic [EP_W-1:0] addr, input logic [LOG_CHAN_W-1:0] chan,
                             input logic [CFG_DATA_W-1:0] data);
        host_write(EP_WR_ADDR, addr);
        host_write(EP_WR_CHAN, 16'(chan));
        for (int i = 0; i < 4; i++) begin
            host_write(8'(EP_DATA0 + i), 16'(data[CFG_SLICE_W*i +: CFG_SLICE_W]));
        end
        host_write(EP_TRIG, trig_word(TRIG_WR_EN));
    endtask

    task automatic clear_logs();
        host_write(EP_TRIG, trig_word(TRIG_LOG_CLEAR));
        for (int k = 0; k < N_LOG; k++) model_log[k] = '0;
        model_pipe.delete();
        model_ovf = 1'b0;
        idle_cycles(2);
    endtask

    // One pulse in the cycle after the trigger write and none the cycle after
    task automatic check_pulse(input trig_bit_e b, input logic [2:0] exp);
        logic [2:0] seen;
        host_write(EP_TRIG, trig_word(b));
        seen = {dac_rset, adc_cstart, cfg_out.en};
        if (seen !== exp) begin
            report_mismatch("{dac_rset,adc_cstart,cfg_out.en}", 64'(seen), 64'(exp));
        end
        next_cycle();
        seen = {dac_rset, adc_cstart, cfg_out.en};
        if (seen !== 3'b000) begin
            report_mismatch("{dac_rset,adc_cstart,cfg_out.en}", 64'(seen), 64'(0));
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("%s: ok", name);
        end else begin
            fail_tests++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic test_reset_state();
        int e0;
        e0 = err_count;
        if (cfg_out.en !== 1'b0) report_mismatch("cfg_out.en", 64'(cfg_out.en), 64'(0));
        if (adc_cstart !== 1'b0) report_mismatch("adc_cstart", 64'(adc_cstart), 64'(0));
        if (dac_rset !== 1'b0) report_mismatch("dac_rset", 64'(dac_rset), 64'(0));
        if (host_rvalid !== 1'b0) report_mismatch("host_rvalid", 64'(host_rvalid), 64'(0));
        for (int k = 0; k < N_LOG; k++) begin
            check_read($sformatf("log word %0d", k), 8'(EP_LOG_BASE + k), 16'h0000);
        end
        check_read("status", EP_STATUS, 16'h0000);
        finish_test("test 1 reset state", e0);
    endtask

    task automatic test_config_write();
        int                    e0;
        logic [EP_W-1:0]       a;
        logic [LOG_CHAN_W-1:0] c;
        logic [CFG_DATA_W-1:0] d;
        e0 = err_count;
        a  = 16'(rand_bits(16));
        // Keep the pipe channel untouched here
        if (a == PIPE_CHAN_ADDR) a = a ^ 16'h0001;
        c = 5'(rand_bits(5));
        d = {16'(rand_bits(16)), rand_bits(32)};
        write_cfg(a, c, d);
        if (cfg_out.en !== 1'b1) report_mismatch("cfg_out.en", 64'(cfg_out.en), 64'(1));
        if (cfg_out.addr !== a) report_mismatch("cfg_out.addr", 64'(cfg_out.addr), 64'(a));
        if (cfg_out.chan !== c) report_mismatch("cfg_out.chan", 64'(cfg_out.chan), 64'(c));
        if (cfg_out.data !== d) report_mismatch("cfg_out.data", 64'(cfg_out.data), 64'(d));
        if (adc_cstart !== 1'b0) report_mismatch("adc_cstart", 64'(adc_cstart), 64'(0));
        if (dac_rset !== 1'b0) report_mismatch("dac_rset", 64'(dac_rset), 64'(0));
        next_cycle();
        if (cfg_out.en !== 1'b0) report_mismatch("cfg_out.en", 64'(cfg_out.en), 64'(0));
        check_pulse(TRIG_ADC_CSTART, 3'b010);
        check_pulse(TRIG_DAC_RSET, 3'b100);
        finish_test("test 2 config write and triggers", e0);
    endtask

    task automatic test_log_capture();
        int          e0;
        logic [31:0] r;
        e0 = err_count;
        for (int k = 0; k < N_LOG; k++) begin
            r = rand_bits(LOG_DATA_W);
            send_sample(5'(k), r[LOG_DATA_W-1:0]);
        end
        // Second sample on channels 1, 4, 7
        for (int k = 1; k < N_LOG; k += 3) begin
            r = rand_bits(LOG_DATA_W);
            send_sample(5'(k), r[LOG_DATA_W-1:0]);
        end
        r = rand_bits(LOG_DATA_W);
        send_sample(5'(N_LOG), r[LOG_DATA_W-1:0]);
        idle_cycles(2);
        for (int k = 0; k < N_LOG; k++) begin
            check_read($sformatf("log word %0d", k), 8'(EP_LOG_BASE + k), model_log[k]);
        end
        check_read("log word past N_LOG", 8'(EP_LOG_BASE + N_LOG), 16'h0000);
        finish_test("test 3 log capture", e0);
    endtask

    task automatic test_pipe_stream();
        int                    e0;
        logic [31:0]           r;
        logic [LOG_CHAN_W-1:0] ch;
        e0 = err_count;
        // Start from an empty pipe since earlier tests fed channel 0
        clear_logs();
        write_cfg(PIPE_CHAN_ADDR, 5'd3, '0);
        model_pipe_chan = 5'd3;
        idle_cycles(2);
        for (int i = 0; i < 24; i++) begin
            r  = rand_bits(LOG_DATA_W + 3);
            ch = (i % 4 == 0) ? 5'd3 : 5'(r[LOG_DATA_W+2:LOG_DATA_W]);
            send_sample(ch, r[LOG_DATA_W-1:0]);
        end
        idle_cycles(2);
        check_read("status", EP_STATUS, expected_status());
        while (model_pipe.size() > 0) begin
            check_read("pipe word", EP_PIPE, model_pipe.pop_front());
        end
        check_read("empty pipe word", EP_PIPE, 16'h0000);
        check_read("status after drain", EP_STATUS, expected_status());
        finish_test("test 4 pipe stream", e0);
    endtask

    task automatic test_fifo_overflow();
        int          e0;
        logic [31:0] r;
        e0 = err_count;
        for (int i = 0; i < DEPTH + 8; i++) begin
            r = rand_bits(LOG_DATA_W);
            send_sample(5'd3, r[LOG_DATA_W-1:0]);
        end
        idle_cycles(2);
        check_read("status when full", EP_STATUS, expected_status());
        while (model_pipe.size() > 0) begin
            check_read("pipe word", EP_PIPE, model_pipe.pop_front());
        end
        clear_logs();
        check_read("status after clear", EP_STATUS, 16'h0000);
        for (int k = 0; k < N_LOG; k++) begin
            check_read($sformatf("log word %0d after clear", k), 8'(EP_LOG_BASE + k), 16'h0000);
        end
        finish_test("test 5 fifo overflow and clear", e0);
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        host_cmd        = '0;
        log_in          = '0;
        sys_rst_out     = 1'b1;
        lfsr_state      = 32'hfb7;
        err_count       = 0;
        pass_tests      = 0;
        fail_tests      = 0;
        model_ovf       = 1'b0;
        model_pipe_chan = '0;
        for (int k = 0; k < N_LOG; k++) model_log[k] = '0;
        model_pipe.delete();
        repeat (2) @(posedge sys_clk_in);
        #1;
        sys_rst_out = 1'b0;

        test_reset_state();
        test_config_write();
        test_log_capture();
        test_pipe_stream();
        test_fifo_overflow();

        $display("tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/fp_pkg.sv
src/fp_host_decode.sv
src/fp_log_capture.sv
src/fp_pipe_fifo.sv
src/fp_readout.sv
src/frontpanel_top.sv
tb/tb_frontpanel.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_frontpanel
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
